// File: cycleQueue.sv
module cycleQueue #(
  parameter int QUEUE_DEPTH = 4
) (
  input logic clk,
  input logic rst,
  cycleReqIf.consumer in,
  cycleReqIf.producer out
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  mclPkg::cycleReqT mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic full;
  logic empty;
  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
      nextPtr = '0;
    end else begin
      nextPtr = ptr + 1'b1;
    end
  endfunction

  assign full = (count == CNT_W'(QUEUE_DEPTH));
  assign empty = (count == '0);

  assign in.ready = ~full;
  assign out.valid = ~empty;
  assign out.req = mem[rdPtr];

  assign push = in.valid & in.ready;
  assign pop = out.valid & out.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      // Simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= in.req;
    end
  end

  // A request offered while full stays with the decoder
  fullHoldCheck: assert property (
    @(posedge clk) disable iff (rst)
    in.valid && full |=> in.valid && $stable(in.req)
  );

  countBoundCheck: assert property (
    @(posedge clk) disable iff (rst)
    count <= CNT_W'(QUEUE_DEPTH)
  );

endmodule

// File: cycleReqIf.sv
interface cycleReqIf;

  logic valid;
  logic ready;
  mclPkg::cycleReqT req;

  // Transfer on an edge with valid and ready both high
  modport producer (
    output valid,
    output req,
    input ready
  );

  modport consumer (
    input valid,
    input req,
    output ready
  );

endinterface

// File: mboxCycleIssuer.sv
module mboxCycleIssuer (
  input  logic clk,
  input  logic rst,
  cycleReqIf.consumer in,
  input  logic mboxAck,
  input  logic [mclPkg::DATA_W-1:0] mboxRdData,
  output logic mboxReq,
  output logic [mclPkg::ADDR_W-1:0] mboxAddr,
  output mclPkg::cycleKindT mboxKind,
  output mclPkg::vmaCtxT mboxCtx,
  output logic [mclPkg::DATA_W-1:0] mboxWrData,
  output logic doneValid,
  output logic [mclPkg::ADDR_W-1:0] doneAddr,
  output mclPkg::cycleKindT doneKind,
  output logic [mclPkg::DATA_W-1:0] doneRdData,
  output logic doneErr
);

  mclPkg::issuerStateE state;
  mclPkg::cycleReqT curReq;
  logic [mclPkg::DATA_W-1:0] rdData;
  logic pop;
  logic isRead;

  // Only accept work once the previous MBOX cycle has fully closed
  assign in.ready = (state == mclPkg::IDLE);
  assign pop = in.valid & in.ready;
  assign isRead = curReq.kind.loadAr | curReq.kind.loadArx;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mclPkg::IDLE;
    end else begin
      unique case (state)
        mclPkg::IDLE: begin
          if (pop) begin
            // Bad address never goes to the MBOX
            state <= in.req.adrErr ? mclPkg::DONE : mclPkg::REQ;
          end
        end
        mclPkg::REQ: begin
          if (mboxAck) begin
            state <= mclPkg::RELEASE;
          end
        end
        mclPkg::RELEASE: begin
          if (!mboxAck) begin
            state <= mclPkg::DONE;
          end
        end
        mclPkg::DONE: begin
          state <= mclPkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      curReq <= in.req;
      rdData <= '0;
    end else if (state == mclPkg::REQ && mboxAck && isRead) begin
      rdData <= mboxRdData;
    end
  end

  // MBOX request side
  assign mboxReq = (state == mclPkg::REQ);
  assign mboxAddr = curReq.addr;
  assign mboxKind = curReq.kind;
  assign mboxCtx = curReq.ctx;
  assign mboxWrData = curReq.wrData;

  // Completion report
  assign doneValid = (state == mclPkg::DONE);
  assign doneAddr = curReq.addr;
  assign doneKind = curReq.kind;
  assign doneRdData = rdData;
  assign doneErr = curReq.adrErr;

  reqStableCheck: assert property (
    @(posedge clk) disable iff (rst)
    mboxReq && !mboxAck |=>
      mboxReq && $stable({mboxAddr, mboxKind, mboxCtx, mboxWrData})
  );

  // Ack must be back low on the edge that raises the next request
  reqRiseCheck: assert property (
    @(posedge clk) disable iff (rst)
    $rose(mboxReq) |-> !$past(mboxAck)
  );

endmodule

// File: mclPkg.sv
package mclPkg;

  // Virtual address is section plus offset
  localparam int SECT_W = 5;
  localparam int OFFS_W = 18;
  localparam int ADDR_W = SECT_W + OFFS_W;

  localparam int DATA_W = 36;

  // Microcode step fields
  localparam int MEM_FIELD_W = 4;
  localparam int MAGIC_W = 9;

  // Memory functions selected by memField bits 1 to 3
  typedef enum logic [2:0] {
    AD_FUNC,
    EA_CALC,
    LOAD_AR,
    LOAD_ARX,
    RW_CYCLE,
    RPW_CYCLE,
    WRITE,
    UNCOND_FETCH
  } memFuncE;

  typedef struct packed {
    logic loadAr;
    logic loadArx;
    logic pause;
    logic write;
    logic fetch;
  } cycleKindT;

  // Address space context for the cycle
  typedef struct packed {
    logic user;
    logic public;
    logic previous;
    logic extended;
  } vmaCtxT;

  localparam int KIND_W = $bits(cycleKindT);
  localparam int CTX_W = $bits(vmaCtxT);

  typedef struct packed {
    cycleKindT kind;
    vmaCtxT ctx;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wrData;
    logic adrErr;
  } cycleReqT;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    RELEASE,
    DONE
  } issuerStateE;

endpackage

// File: mclTop.f
mclPkg.sv
cycleReqIf.sv
memFuncDecoder.sv
cycleQueue.sv
mboxCycleIssuer.sv
mclTop.sv
tbMcl.sv

// File: mclTop.sv
module mclTop #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic uopValid,
  input  logic [mclPkg::MEM_FIELD_W-1:0] memField,
  input  logic [mclPkg::MAGIC_W-1:0] magic,
  input  logic [mclPkg::ADDR_W-1:0] vmaAddr,
  input  logic [mclPkg::DATA_W-1:0] wrData,
  input  logic userMode,
  input  logic publicMode,
  input  logic extendEnable,
  input  logic mboxAck,
  input  logic [mclPkg::DATA_W-1:0] mboxRdData,
  output logic uopReady,
  output logic mboxReq,
  output logic [mclPkg::ADDR_W-1:0] mboxAddr,
  output logic [mclPkg::KIND_W-1:0] mboxKind,
  output logic [mclPkg::CTX_W-1:0] mboxCtx,
  output logic [mclPkg::DATA_W-1:0] mboxWrData,
  output logic doneValid,
  output logic [mclPkg::ADDR_W-1:0] doneAddr,
  output logic [mclPkg::KIND_W-1:0] doneKind,
  output logic [mclPkg::DATA_W-1:0] doneRdData,
  output logic doneErr
);

  mclPkg::cycleKindT mboxKindS;
  mclPkg::vmaCtxT mboxCtxS;
  mclPkg::cycleKindT doneKindS;

  cycleReqIf decToQueue ();
  cycleReqIf queueToIssuer ();

  memFuncDecoder i_decoder (
    .clk(clk),
    .rst(rst),
    .uopValid(uopValid),
    .memField(memField),
    .magic(magic),
    .vmaAddr(vmaAddr),
    .wrData(wrData),
    .userMode(userMode),
    .publicMode(publicMode),
    .extendEnable(extendEnable),
    .uopReady(uopReady),
    .out(decToQueue)
  );

  cycleQueue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_queue (
    .clk(clk),
    .rst(rst),
    .in(decToQueue),
    .out(queueToIssuer)
  );

  mboxCycleIssuer i_issuer (
    .clk(clk),
    .rst(rst),
    .in(queueToIssuer),
    .mboxAck(mboxAck),
    .mboxRdData(mboxRdData),
    .mboxReq(mboxReq),
    .mboxAddr(mboxAddr),
    .mboxKind(mboxKindS),
    .mboxCtx(mboxCtxS),
    .mboxWrData(mboxWrData),
    .doneValid(doneValid),
    .doneAddr(doneAddr),
    .doneKind(doneKindS),
    .doneRdData(doneRdData),
    .doneErr(doneErr)
  );

  // Struct fields out to flat ports
  assign mboxKind = mboxKindS;
  assign mboxCtx = mboxCtxS;
  assign doneKind = doneKindS;

endmodule

// File: memFuncDecoder.sv
module memFuncDecoder (
  input  logic clk,
  input  logic rst,
  input  logic uopValid,
  input  logic [mclPkg::MEM_FIELD_W-1:0] memField,
  input  logic [mclPkg::MAGIC_W-1:0] magic,
  input  logic [mclPkg::ADDR_W-1:0] vmaAddr,
  input  logic [mclPkg::DATA_W-1:0] wrData,
  input  logic userMode,
  input  logic publicMode,
  input  logic extendEnable,
  output logic uopReady,
  cycleReqIf.producer out
);

  mclPkg::memFuncE func;
  mclPkg::cycleKindT kind;
  mclPkg::vmaCtxT ctx;
  mclPkg::cycleReqT reqReg;
  logic [mclPkg::SECT_W-1:0] section;
  logic isAdFunc;
  logic adrErr;
  logic produce;
  logic accept;
  logic validReg;
  logic armed;

  assign func = mclPkg::memFuncE'(memField[mclPkg::MEM_FIELD_W-1:1]);
  assign section = vmaAddr[mclPkg::ADDR_W-1 -: mclPkg::SECT_W];
  assign isAdFunc = (func == mclPkg::AD_FUNC);

  // Cycle kind per memory function
  always_comb begin
    kind = '0;
    unique case (func)
      mclPkg::LOAD_AR: begin
        kind.loadAr = 1'b1;
      end
      mclPkg::LOAD_ARX: begin
        kind.loadArx = 1'b1;
      end
      mclPkg::RW_CYCLE: begin
        kind.loadAr = 1'b1;
        kind.write = 1'b1;
      end
      mclPkg::RPW_CYCLE: begin
        kind.loadAr = 1'b1;
        kind.pause = 1'b1;
        kind.write = 1'b1;
      end
      mclPkg::WRITE: begin
        kind.write = 1'b1;
      end
      mclPkg::UNCOND_FETCH: begin
        kind.loadArx = 1'b1;
        kind.fetch = 1'b1;
      end
      mclPkg::EA_CALC, mclPkg::AD_FUNC: begin
        // Kind comes straight from the magic field
        kind.loadAr = magic[0];
        kind.loadArx = magic[1];
        kind.pause = magic[2];
        kind.write = magic[3];
      end
    endcase
  end

  // Address context
  always_comb begin
    ctx.user = isAdFunc ? magic[1] : userMode;
    ctx.public = publicMode & ~ctx.user;
    ctx.previous = (func == mclPkg::EA_CALC) & magic[5];
    ctx.extended = (section != '0);
  end

  // Section bits need extended addressing, except for AD_FUNC
  assign adrErr = (section != '0) & ~extendEnable & ~isAdFunc;

  assign produce = memField[0] & (kind != '0);

  // Ready waits one cycle after reset
  assign uopReady = armed & (~validReg | out.ready);
  assign accept = uopValid & uopReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      validReg <= 1'b0;
      armed <= 1'b0;
    end else begin
      armed <= 1'b1;
      if (accept) begin
        validReg <= produce;
      end else if (out.ready) begin
        validReg <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqReg.kind <= kind;
      reqReg.ctx <= ctx;
      reqReg.addr <= vmaAddr;
      reqReg.wrData <= wrData;
      reqReg.adrErr <= adrErr;
    end
  end

  assign out.valid = validReg;
  assign out.req = reqReg;

  // Dropped steps must never reach the queue
  validKindCheck: assert property (
    @(posedge clk) disable iff (rst)
    out.valid |-> (out.req.kind != '0)
  );

endmodule

// File: tbMcl.sv
module tbMcl;

  localparam int ADDR_W = mclPkg::ADDR_W;
  localparam int DATA_W = mclPkg::DATA_W;
  localparam int RAND_STEPS = 40;
  localparam int TOTAL_STEPS = 6 + 8 + 5 + 6 + RAND_STEPS + 12;
  // Per-step budget plus the two reset windows
  localparam int TIMEOUT_CYCLES = TOTAL_STEPS * 20 + 2 * 16;

  logic clk;
  logic rst;
  logic uopValid;
  logic [mclPkg::MEM_FIELD_W-1:0] memField;
  logic [mclPkg::MAGIC_W-1:0] magic;
  logic [ADDR_W-1:0] vmaAddr;
  logic [DATA_W-1:0] wrData;
  logic userMode;
  logic publicMode;
  logic extendEnable;
  logic mboxAck;
  logic [DATA_W-1:0] mboxRdData;
  logic uopReady;
  logic mboxReq;
  logic [ADDR_W-1:0] mboxAddr;
  logic [mclPkg::KIND_W-1:0] mboxKind;
  logic [mclPkg::CTX_W-1:0] mboxCtx;
  logic [DATA_W-1:0] mboxWrData;
  logic doneValid;
  logic [ADDR_W-1:0] doneAddr;
  logic [mclPkg::KIND_W-1:0] doneKind;
  logic [DATA_W-1:0] doneRdData;
  logic doneErr;

  int seed = 32'hf059;
  int ackSeed = ~32'hf059;
  int ackWait = -1;
  int ackExtra = 0;
  int errCount = 0;
  int errAtStart = 0;
  int checkCount = 0;
  int testCount = 0;
  int failCount = 0;
  logic prevReq;
  logic prevAck;
  logic sawStall;
  mclPkg::cycleReqT expQ[$];

  mclTop #(.QUEUE_DEPTH(4)) i_dut (.*);

  always #5 clk = ~clk;

  // Expected request by the memory field rules; empty kind means no request
  function automatic mclPkg::cycleReqT expectReq(input logic [3:0] mf, input logic [8:0] mg,
      input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wd, input logic um,
      input logic pm, input logic ee);
    mclPkg::cycleReqT r;
    mclPkg::memFuncE fn;
    logic sectNz;
    fn = mclPkg::memFuncE'(mf[3:1]);
    sectNz = (addr[ADDR_W-1:mclPkg::OFFS_W] != 0);
    r = '0;
    case (fn)
      mclPkg::LOAD_AR: r.kind.loadAr = 1'b1;
      mclPkg::LOAD_ARX: r.kind.loadArx = 1'b1;
      mclPkg::RW_CYCLE: r.kind = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
      mclPkg::RPW_CYCLE: r.kind = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
      mclPkg::WRITE: r.kind.write = 1'b1;
      mclPkg::UNCOND_FETCH: r.kind = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
      default: r.kind = '{mg[0], mg[1], mg[2], mg[3], 1'b0};
    endcase
    r.ctx.user = (fn == mclPkg::AD_FUNC) ? mg[1] : um;
    r.ctx.public = pm && !r.ctx.user;
    r.ctx.previous = (fn == mclPkg::EA_CALC) && mg[5];
    r.ctx.extended = sectNz;
    r.addr = addr;
    r.wrData = wd;
    r.adrErr = sectNz && !ee && (fn != mclPkg::AD_FUNC);
    if (!mf[0]) begin
      r.kind = '0;
    end
    return r;
  endfunction

  function automatic logic [DATA_W-1:0] memWord(input logic [ADDR_W-1:0] addr);
    return {addr[12:0], addr} ^ 36'h5a5a5a5a5;
  endfunction

  function automatic logic [DATA_W-1:0] expectRdData(input mclPkg::cycleReqT e);
    if (e.adrErr || !(e.kind.loadAr || e.kind.loadArx)) begin
      return '0;
    end
    return memWord(e.addr);
  endfunction

  task automatic flagError(input string msg);
    errCount++;
    $display("ERROR: %s at time %0t", msg, $time);
  endtask

  task automatic compareKind(input string name, input mclPkg::cycleKindT got,
      input mclPkg::cycleKindT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compareCtx(input string name, input mclPkg::vmaCtxT got,
      input mclPkg::vmaCtxT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compareAddr(input string name, input logic [ADDR_W-1:0] got,
      input logic [ADDR_W-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compareData(input string name, input logic [DATA_W-1:0] got,
      input logic [DATA_W-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compareErr(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Called 1 unit after an edge; returns 1 unit after the accepting edge
  task automatic sendStep(input logic [3:0] mf, input logic [8:0] mg,
      input logic [ADDR_W-1:0] addr);
    mclPkg::cycleReqT r;
    logic acc;
    uopValid = 1'b1;
    memField = mf;
    magic = mg;
    vmaAddr = addr;
    wrData = DATA_W'({$random(seed), $random(seed)});
    r = expectReq(mf, mg, addr, wrData, userMode, publicMode, extendEnable);
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = uopReady;
      @(posedge clk);
      #1;
    end
    if (r.kind != '0) begin
      expQ.push_back(r);
    end
    uopValid = 1'b0;
  endtask

  task automatic finishTest(input string name);
    while (expQ.size() != 0) begin
      @(posedge clk);
    end
    // Room for any stray pulse to show up
    repeat (8) @(posedge clk);
    #1;
    testCount++;
    if (errCount == errAtStart) begin
      $display("%s: passed", name);
    end else begin
      failCount++;
      $display("%s: failed with %0d errors", name, errCount - errAtStart);
    end
    errAtStart = errCount;
  endtask

  // MBOX model with random ack delays
  always @(posedge clk) begin
    #1;
    if (rst) begin
      mboxAck = 1'b0;
      ackWait = -1;
    end else if (mboxReq != mboxAck) begin
      if (ackWait < 0) begin
        ackWait = $unsigned($random(ackSeed)) % 6 + ackExtra;
      end
      if (ackWait == 0) begin
        if (mboxReq) begin
          mboxRdData = memWord(mboxAddr);
        end
        mboxAck = mboxReq;
        ackWait = -1;
      end else begin
        ackWait--;
      end
    end
  end

  always @(negedge clk) begin
    mclPkg::cycleReqT e;
    if (rst) begin
      prevReq = 1'b0;
      prevAck = 1'b0;
    end else begin
      if (uopValid && !uopReady) begin
        sawStall = 1'b1;
      end
      if (mboxReq && !prevReq) begin
        if (prevAck) begin
          flagError("mboxReq rose while mboxAck was still high");
        end
        if (expQ.size() == 0) begin
          flagError("mboxReq raised with no request outstanding");
        end else begin
          e = expQ[0];
          if (e.adrErr) begin
            flagError("mboxReq raised for an address-error request");
          end
          compareKind("mboxKind", mboxKind, e.kind);
          compareCtx("mboxCtx", mboxCtx, e.ctx);
          compareAddr("mboxAddr", mboxAddr, e.addr);
          compareData("mboxWrData", mboxWrData, e.wrData);
        end
      end
      if (prevReq && !mboxReq && !prevAck) begin
        flagError("mboxReq dropped before mboxAck arrived");
      end
      if (doneValid) begin
        if (expQ.size() == 0) begin
          flagError("doneValid pulsed with no request outstanding");
        end else begin
          e = expQ.pop_front();
          compareAddr("doneAddr", doneAddr, e.addr);
          compareKind("doneKind", doneKind, e.kind);
          compareErr("doneErr", doneErr, e.adrErr);
          compareData("doneRdData", doneRdData, expectRdData(e));
        end
      end
      prevReq = mboxReq;
      prevAck = mboxAck;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: traffic did not complete within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    uopValid = 1'b0;
    memField = '0;
    magic = '0;
    vmaAddr = '0;
    wrData = '0;
    userMode = 1'b0;
    publicMode = 1'b1;
    extendEnable = 1'b0;
    mboxAck = 1'b0;
    mboxRdData = '0;
    sawStall = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int f = 2; f < 8; f++) begin
      sendStep({3'(f), 1'b1}, 9'h1ff, {5'd0, 18'($random(seed))});
    end
    finishTest("Test 1 fixed functions");

    userMode = 1'b1;
    sendStep({mclPkg::EA_CALC, 1'b1}, 9'h001, {5'd0, 18'($random(seed))});
    sendStep({mclPkg::EA_CALC, 1'b1}, 9'h00a, {5'd0, 18'($random(seed))});
    sendStep({mclPkg::EA_CALC, 1'b1}, 9'h02f, {5'd0, 18'($random(seed))});
    sendStep({mclPkg::EA_CALC, 1'b1}, 9'h000, {5'd0, 18'($random(seed))});
    sendStep({mclPkg::AD_FUNC, 1'b1}, 9'h002, {5'd0, 18'($random(seed))});
    sendStep({mclPkg::AD_FUNC, 1'b1}, 9'h00d, {5'd0, 18'($random(seed))});
    sendStep({mclPkg::AD_FUNC, 1'b1}, 9'h000, {5'd0, 18'($random(seed))});
    sendStep({mclPkg::EA_CALC, 1'b1}, 9'h024, {5'd0, 18'($random(seed))});
    finishTest("Test 2 magic-driven functions");

    userMode = 1'b0;
    sendStep({mclPkg::LOAD_AR, 1'b1}, 9'h0, {5'd3, 18'h01234});
    sendStep({mclPkg::WRITE, 1'b1}, 9'h0, {5'd1, 18'h3ffff});
    sendStep({mclPkg::AD_FUNC, 1'b1}, 9'h001, {5'd3, 18'h01234});
    extendEnable = 1'b1;
    sendStep({mclPkg::LOAD_AR, 1'b1}, 9'h0, {5'd3, 18'h01234});
    sendStep({mclPkg::UNCOND_FETCH, 1'b1}, 9'h0, {5'd31, 18'h00777});
    finishTest("Test 3 section address errors");

    for (int i = 0; i < 6; i++) begin
      sendStep({mclPkg::RW_CYCLE, i[0]}, 9'h00f, {5'd0, 18'($random(seed))});
    end
    finishTest("Test 4 disabled memory field");

    ackExtra = 3;
    sawStall = 1'b0;
    for (int i = 0; i < RAND_STEPS; i++) begin
      userMode = 1'($random(seed));
      publicMode = 1'($random(seed));
      extendEnable = 1'($random(seed));
      sendStep({3'($random(seed)), ($unsigned($random(seed)) % 8) != 0},
               9'($random(seed)), {5'($unsigned($random(seed)) % 3), 18'($random(seed))});
    end
    if (!sawStall) begin
      flagError("uopReady never went low under back-pressure");
    end
    finishTest("Test 5 random stream with slow MBOX");
    ackExtra = 0;

    for (int i = 0; i < 6; i++) begin
      sendStep({mclPkg::LOAD_ARX, 1'b1}, 9'h0, {5'd0, 18'($random(seed))});
    end
    rst = 1'b1;
    expQ.delete();
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    if (mboxReq || doneValid || uopReady || i_dut.i_queue.count != 0) begin
      flagError("outputs not idle or queue not empty right after reset");
    end
    for (int i = 0; i < 6; i++) begin
      sendStep({mclPkg::RPW_CYCLE, 1'b1}, 9'h0, {5'd0, 18'($random(seed))});
    end
    finishTest("Test 6 reset in mid-stream");

    $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
             testCount, failCount, checkCount, errCount);
    if (errCount == 0 && failCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
